// ==== src/burst_pkg.sv ====
package burst_pkg;

  // Burst length as carried on AXI, beats minus one
  typedef logic [7:0] len_t;

  // AXI response code
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // Write splitter FSM
  typedef enum logic [1:0] {
    W_IDLE,
    W_BEAT,
    W_RESP,
    W_DONE
  } wr_state_e;

  // Read splitter FSM
  typedef enum logic [1:0] {
    R_IDLE,
    R_ADDR,
    R_DATA
  } rd_state_e;

endpackage

// ==== src/burst_split_wr.sv ====
`timescale 1ns/100ps

module burst_split_wr
  import burst_pkg::*;
#(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 16,
  parameter int ID_WIDTH   = 4
) (
  input  logic                    clk,
  input  logic                    i_arst_n,

  input  logic                    i_s_awvalid,
  input  logic [  ID_WIDTH-1:0]   i_s_awid,
  input  logic [ADDR_WIDTH-1:0]   i_s_awaddr,
  input  len_t                    i_s_awlen,
  output logic                    o_s_awready,
  input  logic                    i_s_wvalid,
  input  logic [DATA_WIDTH-1:0]   i_s_wdata,
  input  logic [DATA_WIDTH/8-1:0] i_s_wstrb,
  input  logic                    i_s_wlast,
  output logic                    o_s_wready,
  output logic                    o_s_bvalid,
  output logic [  ID_WIDTH-1:0]   o_s_bid,
  output resp_t                   o_s_bresp,
  input  logic                    i_s_bready,

  output logic                    o_m_awvalid,
  output logic [ADDR_WIDTH-1:0]   o_m_awaddr,
  output logic [  ID_WIDTH-1:0]   o_m_awid,
  output len_t                    o_m_awlen,
  input  logic                    i_m_awready,
  output logic                    o_m_wvalid,
  output logic [DATA_WIDTH-1:0]   o_m_wdata,
  output logic [DATA_WIDTH/8-1:0] o_m_wstrb,
  output logic                    o_m_wlast,
  input  logic                    i_m_wready,
  input  logic                    i_m_bvalid,
  input  resp_t                   i_m_bresp,
  output logic                    o_m_bready
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  wr_state_e             state;
  logic [  ID_WIDTH-1:0] id_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  len_t                  len_q;
  len_t                  beat_cnt;
  logic                  err_q;

  // Held beat that forms the single write in flight
  logic                  aw_pend;
  logic                  w_pend;
  logic [DATA_WIDTH-1:0] data_q;
  logic [STRB_WIDTH-1:0] strb_q;

  logic s_aw_fire;
  logic s_w_fire;
  logic m_aw_fire;
  logic m_w_fire;
  logic m_b_fire;
  logic aw_left;
  logic w_left;
  logic last_beat;

  assign o_s_awready = (state == W_IDLE);
  // Next subordinate beat only once the held one has fully left
  assign o_s_wready  = (state == W_BEAT) && !aw_pend && !w_pend;

  assign s_aw_fire = i_s_awvalid && o_s_awready;
  assign s_w_fire  = i_s_wvalid && o_s_wready;
  assign m_aw_fire = o_m_awvalid && i_m_awready;
  assign m_w_fire  = o_m_wvalid && i_m_wready;
  assign m_b_fire  = i_m_bvalid && o_m_bready;

  assign aw_left   = aw_pend && !m_aw_fire;
  assign w_left    = w_pend && !m_w_fire;
  assign last_beat = (beat_cnt == len_q);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= W_IDLE;
      beat_cnt <= '0;
      err_q    <= 1'b0;
      aw_pend  <= 1'b0;
      w_pend   <= 1'b0;
    end else begin
      case (state)
        W_IDLE: begin
          if (s_aw_fire) begin
            beat_cnt <= '0;
            err_q    <= 1'b0;
            state    <= W_BEAT;
          end
        end
        W_BEAT: begin
          if (s_w_fire) begin
            aw_pend <= 1'b1;
            w_pend  <= 1'b1;
          end else if (aw_pend || w_pend) begin
            aw_pend <= aw_left;
            w_pend  <= w_left;
            if (!aw_left && !w_left) begin
              state <= W_RESP;
            end
          end
        end
        W_RESP: begin
          if (m_b_fire) begin
            err_q <= err_q | (i_m_bresp == RESP_SLVERR);
            if (last_beat) begin
              state <= W_DONE;
            end else begin
              beat_cnt <= len_t'(beat_cnt + 1'b1);
              state    <= W_BEAT;
            end
          end
        end
        W_DONE: begin
          if (i_s_bready) begin
            state <= W_IDLE;
          end
        end
        default: state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_aw_fire) begin
      id_q   <= i_s_awid;
      addr_q <= i_s_awaddr;
      len_q  <= i_s_awlen;
    end else if (m_b_fire && !last_beat) begin
      addr_q <= addr_q + ADDR_WIDTH'(STRB_WIDTH);
    end
    if (s_w_fire) begin
      data_q <= i_s_wdata;
      strb_q <= i_s_wstrb;
    end
  end

  assign o_m_awvalid = aw_pend;
  assign o_m_awaddr  = addr_q;
  assign o_m_awid    = id_q;
  assign o_m_awlen   = '0;
  assign o_m_wvalid  = w_pend;
  assign o_m_wdata   = data_q;
  assign o_m_wstrb   = strb_q;
  assign o_m_wlast   = 1'b1;
  assign o_m_bready  = (state == W_RESP);

  // One merged response per burst
  assign o_s_bvalid = (state == W_DONE);
  assign o_s_bid    = id_q;
  assign o_s_bresp  = err_q ? RESP_SLVERR : RESP_OKAY;

  // Manager must not close the burst early
  ap_wlast_on_last: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    s_w_fire && i_s_wlast |-> last_beat
  );

  // Memory responds only once both halves of the held beat have left
  ap_b_in_resp: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    i_m_bvalid |-> state == W_RESP
  );

endmodule

// ==== src/burst_split_rd.sv ====
`timescale 1ns/100ps

module burst_split_rd
  import burst_pkg::*;
#(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 16,
  parameter int ID_WIDTH   = 4
) (
  input  logic                  clk,
  input  logic                  i_arst_n,

  input  logic                  i_s_arvalid,
  input  logic [  ID_WIDTH-1:0] i_s_arid,
  input  logic [ADDR_WIDTH-1:0] i_s_araddr,
  input  len_t                  i_s_arlen,
  output logic                  o_s_arready,
  output logic                  o_s_rvalid,
  output logic [  ID_WIDTH-1:0] o_s_rid,
  output logic [DATA_WIDTH-1:0] o_s_rdata,
  output resp_t                 o_s_rresp,
  output logic                  o_s_rlast,
  input  logic                  i_s_rready,

  output logic                  o_m_arvalid,
  output logic [ADDR_WIDTH-1:0] o_m_araddr,
  output logic [  ID_WIDTH-1:0] o_m_arid,
  output len_t                  o_m_arlen,
  input  logic                  i_m_arready,
  input  logic                  i_m_rvalid,
  input  logic [DATA_WIDTH-1:0] i_m_rdata,
  input  resp_t                 i_m_rresp,
  output logic                  o_m_rready
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  rd_state_e             state;
  logic [  ID_WIDTH-1:0] id_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  len_t                  len_q;
  len_t                  beat_cnt;

  logic s_ar_fire;
  logic m_ar_fire;
  logic m_r_fire;
  logic last_beat;

  assign o_s_arready = (state == R_IDLE);

  assign s_ar_fire = i_s_arvalid && o_s_arready;
  assign m_ar_fire = o_m_arvalid && i_m_arready;
  assign m_r_fire  = i_m_rvalid && o_m_rready;
  assign last_beat = (beat_cnt == len_q);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state    <= R_IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        R_IDLE: begin
          if (s_ar_fire) begin
            beat_cnt <= '0;
            state    <= R_ADDR;
          end
        end
        R_ADDR: begin
          if (m_ar_fire) begin
            state <= R_DATA;
          end
        end
        R_DATA: begin
          // Next address goes out only after this beat is taken upstream
          if (m_r_fire) begin
            if (last_beat) begin
              state <= R_IDLE;
            end else begin
              beat_cnt <= len_t'(beat_cnt + 1'b1);
              state    <= R_ADDR;
            end
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_ar_fire) begin
      id_q   <= i_s_arid;
      addr_q <= i_s_araddr;
      len_q  <= i_s_arlen;
    end else if (m_r_fire && !last_beat) begin
      addr_q <= addr_q + ADDR_WIDTH'(STRB_WIDTH);
    end
  end

  assign o_m_arvalid = (state == R_ADDR);
  assign o_m_araddr  = addr_q;
  assign o_m_arid    = id_q;
  assign o_m_arlen   = '0;

  // Straight pass of the read beat, back-pressure included
  assign o_m_rready = i_s_rready;
  assign o_s_rvalid = i_m_rvalid;
  assign o_s_rid    = id_q;
  assign o_s_rdata  = i_m_rdata;
  assign o_s_rresp  = i_m_rresp;
  assign o_s_rlast  = last_beat;

  // Memory answers only the address this splitter issued
  ap_r_in_data: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    o_s_rvalid |-> state == R_DATA
  );

endmodule

// ==== src/beat_mem.sv ====
`timescale 1ns/100ps

module beat_mem
  import burst_pkg::*;
#(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 16,
  parameter int ID_WIDTH   = 4,
  parameter int MEM_DEPTH  = 64
) (
  input  logic                    clk,
  input  logic                    i_arst_n,

  input  logic                    i_awvalid,
  input  logic [ADDR_WIDTH-1:0]   i_awaddr,
  input  logic [  ID_WIDTH-1:0]   i_awid,
  input  len_t                    i_awlen,
  output logic                    o_awready,
  input  logic                    i_wvalid,
  input  logic [DATA_WIDTH-1:0]   i_wdata,
  input  logic [DATA_WIDTH/8-1:0] i_wstrb,
  input  logic                    i_wlast,
  output logic                    o_wready,
  output logic                    o_bvalid,
  output logic [  ID_WIDTH-1:0]   o_bid,
  output resp_t                   o_bresp,
  input  logic                    i_bready,

  input  logic                    i_arvalid,
  input  logic [ADDR_WIDTH-1:0]   i_araddr,
  input  logic [  ID_WIDTH-1:0]   i_arid,
  input  len_t                    i_arlen,
  output logic                    o_arready,
  output logic                    o_rvalid,
  output logic [  ID_WIDTH-1:0]   o_rid,
  output logic [DATA_WIDTH-1:0]   o_rdata,
  output resp_t                   o_rresp,
  output logic                    o_rlast,
  input  logic                    i_rready
);

  localparam int STRB_WIDTH   = DATA_WIDTH / 8;
  localparam int OFFSET_WIDTH = $clog2(STRB_WIDTH);
  localparam int WORD_WIDTH   = ADDR_WIDTH - OFFSET_WIDTH;
  localparam int MEM_AW       = $clog2(MEM_DEPTH);

  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

  logic [WORD_WIDTH-1:0] wr_word;
  logic [WORD_WIDTH-1:0] rd_word;
  logic                  wr_in_range;
  logic                  rd_in_range;
  logic                  wr_fire;
  logic                  rd_fire;

  assign wr_word     = i_awaddr[ADDR_WIDTH-1:OFFSET_WIDTH];
  assign rd_word     = i_araddr[ADDR_WIDTH-1:OFFSET_WIDTH];
  assign wr_in_range = 32'(wr_word) < MEM_DEPTH;
  assign rd_in_range = 32'(rd_word) < MEM_DEPTH;

  // Address and data are taken together, one write per response
  assign o_awready = !o_bvalid;
  assign o_wready  = !o_bvalid;
  assign o_arready = !o_rvalid;
  assign wr_fire   = i_awvalid && i_wvalid && !o_bvalid;
  assign rd_fire   = i_arvalid && !o_rvalid;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_bvalid <= 1'b0;
      o_rvalid <= 1'b0;
    end else begin
      if (wr_fire) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
      if (rd_fire) begin
        o_rvalid <= 1'b1;
      end else if (i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      o_bid   <= i_awid;
      o_bresp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
      if (wr_in_range) begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
          if (i_wstrb[b]) begin
            mem[wr_word[MEM_AW-1:0]][b*8 +: 8] <= i_wdata[b*8 +: 8];
          end
        end
      end
    end
    if (rd_fire) begin
      o_rid   <= i_arid;
      o_rresp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
      o_rdata <= rd_in_range ? mem[rd_word[MEM_AW-1:0]] : '0;
    end
  end

  assign o_rlast = o_rvalid;

  // Only single-beat traffic reaches this memory
  ap_wr_single: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    wr_fire |-> i_awlen == '0 && i_wlast
  );

  ap_rd_single: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    rd_fire |-> i_arlen == '0
  );

endmodule

// ==== src/burst_split_top.sv ====
`timescale 1ns/100ps

module burst_split_top
  import burst_pkg::*;
#(
  parameter int ADDR_WIDTH = 8,
  parameter int DATA_WIDTH = 16,
  parameter int ID_WIDTH   = 4,
  parameter int MEM_DEPTH  = 64
) (
  input  logic                    clk,
  input  logic                    i_arst_n,

  input  logic                    i_s_awvalid,
  input  logic [  ID_WIDTH-1:0]   i_s_awid,
  input  logic [ADDR_WIDTH-1:0]   i_s_awaddr,
  input  len_t                    i_s_awlen,
  output logic                    o_s_awready,
  input  logic                    i_s_wvalid,
  input  logic [DATA_WIDTH-1:0]   i_s_wdata,
  input  logic [DATA_WIDTH/8-1:0] i_s_wstrb,
  input  logic                    i_s_wlast,
  output logic                    o_s_wready,
  output logic                    o_s_bvalid,
  output logic [  ID_WIDTH-1:0]   o_s_bid,
  output resp_t                   o_s_bresp,
  input  logic                    i_s_bready,

  input  logic                    i_s_arvalid,
  input  logic [  ID_WIDTH-1:0]   i_s_arid,
  input  logic [ADDR_WIDTH-1:0]   i_s_araddr,
  input  len_t                    i_s_arlen,
  output logic                    o_s_arready,
  output logic                    o_s_rvalid,
  output logic [  ID_WIDTH-1:0]   o_s_rid,
  output logic [DATA_WIDTH-1:0]   o_s_rdata,
  output resp_t                   o_s_rresp,
  output logic                    o_s_rlast,
  input  logic                    i_s_rready
);

  // Single-beat channels between the splitters and the memory
  logic                    m_awvalid;
  logic [ADDR_WIDTH-1:0]   m_awaddr;
  logic [  ID_WIDTH-1:0]   m_awid;
  len_t                    m_awlen;
  logic                    m_awready;
  logic                    m_wvalid;
  logic [DATA_WIDTH-1:0]   m_wdata;
  logic [DATA_WIDTH/8-1:0] m_wstrb;
  logic                    m_wlast;
  logic                    m_wready;
  logic                    m_bvalid;
  resp_t                   m_bresp;
  logic                    m_bready;
  logic                    m_arvalid;
  logic [ADDR_WIDTH-1:0]   m_araddr;
  logic [  ID_WIDTH-1:0]   m_arid;
  len_t                    m_arlen;
  logic                    m_arready;
  logic                    m_rvalid;
  logic [DATA_WIDTH-1:0]   m_rdata;
  resp_t                   m_rresp;
  logic                    m_rready;

  burst_split_wr #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH)
  ) u_split_wr (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_s_awvalid (i_s_awvalid),
    .i_s_awid    (i_s_awid),
    .i_s_awaddr  (i_s_awaddr),
    .i_s_awlen   (i_s_awlen),
    .o_s_awready (o_s_awready),
    .i_s_wvalid  (i_s_wvalid),
    .i_s_wdata   (i_s_wdata),
    .i_s_wstrb   (i_s_wstrb),
    .i_s_wlast   (i_s_wlast),
    .o_s_wready  (o_s_wready),
    .o_s_bvalid  (o_s_bvalid),
    .o_s_bid     (o_s_bid),
    .o_s_bresp   (o_s_bresp),
    .i_s_bready  (i_s_bready),
    .o_m_awvalid (m_awvalid),
    .o_m_awaddr  (m_awaddr),
    .o_m_awid    (m_awid),
    .o_m_awlen   (m_awlen),
    .i_m_awready (m_awready),
    .o_m_wvalid  (m_wvalid),
    .o_m_wdata   (m_wdata),
    .o_m_wstrb   (m_wstrb),
    .o_m_wlast   (m_wlast),
    .i_m_wready  (m_wready),
    .i_m_bvalid  (m_bvalid),
    .i_m_bresp   (m_bresp),
    .o_m_bready  (m_bready)
  );

  burst_split_rd #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH)
  ) u_split_rd (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_s_arvalid (i_s_arvalid),
    .i_s_arid    (i_s_arid),
    .i_s_araddr  (i_s_araddr),
    .i_s_arlen   (i_s_arlen),
    .o_s_arready (o_s_arready),
    .o_s_rvalid  (o_s_rvalid),
    .o_s_rid     (o_s_rid),
    .o_s_rdata   (o_s_rdata),
    .o_s_rresp   (o_s_rresp),
    .o_s_rlast   (o_s_rlast),
    .i_s_rready  (i_s_rready),
    .o_m_arvalid (m_arvalid),
    .o_m_araddr  (m_araddr),
    .o_m_arid    (m_arid),
    .o_m_arlen   (m_arlen),
    .i_m_arready (m_arready),
    .i_m_rvalid  (m_rvalid),
    .i_m_rdata   (m_rdata),
    .i_m_rresp   (m_rresp),
    .o_m_rready  (m_rready)
  );

  // Memory ID and rlast echoes are not needed, the splitters keep their own
  beat_mem #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_mem (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_awvalid (m_awvalid),
    .i_awaddr  (m_awaddr),
    .i_awid    (m_awid),
    .i_awlen   (m_awlen),
    .o_awready (m_awready),
    .i_wvalid  (m_wvalid),
    .i_wdata   (m_wdata),
    .i_wstrb   (m_wstrb),
    .i_wlast   (m_wlast),
    .o_wready  (m_wready),
    .o_bvalid  (m_bvalid),
    .o_bid     (),
    .o_bresp   (m_bresp),
    .i_bready  (m_bready),
    .i_arvalid (m_arvalid),
    .i_araddr  (m_araddr),
    .i_arid    (m_arid),
    .i_arlen   (m_arlen),
    .o_arready (m_arready),
    .o_rvalid  (m_rvalid),
    .o_rid     (),
    .o_rdata   (m_rdata),
    .o_rresp   (m_rresp),
    .o_rlast   (),
    .i_rready  (m_rready)
  );

endmodule

// ==== verification/burst_split_tb.sv ====
`timescale 1ns/100ps

module burst_split_tb
  import burst_pkg::*;
();

  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 16;
  localparam int ID_WIDTH   = 4;
  localparam int MEM_DEPTH  = 64;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int MEM_BYTES  = MEM_DEPTH * STRB_WIDTH;
  localparam int CLK_PERIOD = 8;
  localparam int TIMEOUT    = 1000;

  // Channels whose handshake a manager task waits for
  localparam int CH_AW = 0;
  localparam int CH_W  = 1;
  localparam int CH_AR = 2;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    resp_t                 resp;
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } rbeat_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    resp_t               resp;
  } wresp_t;

  logic                  clk;
  logic                  i_arst_n;
  logic                  i_s_awvalid;
  logic [ID_WIDTH-1:0]   i_s_awid;
  logic [ADDR_WIDTH-1:0] i_s_awaddr;
  len_t                  i_s_awlen;
  logic                  o_s_awready;
  logic                  i_s_wvalid;
  logic [DATA_WIDTH-1:0] i_s_wdata;
  logic [STRB_WIDTH-1:0] i_s_wstrb;
  logic                  i_s_wlast;
  logic                  o_s_wready;
  logic                  o_s_bvalid;
  logic [ID_WIDTH-1:0]   o_s_bid;
  resp_t                 o_s_bresp;
  logic                  i_s_bready;
  logic                  i_s_arvalid;
  logic [ID_WIDTH-1:0]   i_s_arid;
  logic [ADDR_WIDTH-1:0] i_s_araddr;
  len_t                  i_s_arlen;
  logic                  o_s_arready;
  logic                  o_s_rvalid;
  logic [ID_WIDTH-1:0]   o_s_rid;
  logic [DATA_WIDTH-1:0] o_s_rdata;
  resp_t                 o_s_rresp;
  logic                  o_s_rlast;
  logic                  i_s_rready;

  integer     seed;
  logic       stall_en;
  logic [7:0] ref_mem [2**ADDR_WIDTH];
  rbeat_t     exp_r [$];
  wresp_t     exp_b [$];
  rbeat_t     r_exp;
  wresp_t     b_exp;

  burst_split_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic string value_error(input string name, input logic [31:0] got,
                                        input logic [31:0] exp);
    return $sformatf("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, got, exp);
  endfunction

  // Expected {resp, data} of one beat with zero data and SLVERR beyond the memory
  function automatic logic [DATA_WIDTH+1:0] expected_read(input int addr);
    logic [DATA_WIDTH-1:0] data;
    int                    word;
    word = addr / STRB_WIDTH;
    if (word >= MEM_DEPTH) begin
      return {RESP_SLVERR, {DATA_WIDTH{1'b0}}};
    end
    for (int b = 0; b < STRB_WIDTH; b++) begin
      data[b*8 +: 8] = ref_mem[word * STRB_WIDTH + b];
    end
    return {RESP_OKAY, data};
  endfunction

  function automatic bit channel_fired(input int ch);
    case (ch)
      CH_AW:   return i_s_awvalid && o_s_awready;
      CH_W:    return i_s_wvalid && o_s_wready;
      default: return i_s_arvalid && o_s_arready;
    endcase
  endfunction

  task automatic wait_handshake(input int ch, input string what);
    int waited;
    waited = 0;
    @(posedge clk);
    while (!channel_fired(ch)) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_failure($sformatf("Timeout: the %s handshake never completed", what));
      end
      @(posedge clk);
    end
  endtask

  // Burst is over once the checker has consumed every expected response
  task automatic wait_responses(input string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_r.size() != 0 || exp_b.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) begin
        report_failure($sformatf("Timeout: the %s never delivered all responses", what));
      end
      @(negedge clk);
    end
  endtask

  task automatic write_burst(input int addr, input int beats, input bit partial);
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    wresp_t                b_new;
    int                    baddr;
    bit                    err;
    id  = ID_WIDTH'($random(seed));
    err = 1'b0;
    for (int i = 0; i < beats; i++) begin
      if ((addr + i * STRB_WIDTH) / STRB_WIDTH >= MEM_DEPTH) begin
        err = 1'b1;
      end
    end
    b_new.id   = id;
    b_new.resp = err ? RESP_SLVERR : RESP_OKAY;
    exp_b.push_back(b_new);

    @(negedge clk);
    i_s_awvalid = 1'b1;
    i_s_awid    = id;
    i_s_awaddr  = ADDR_WIDTH'(addr);
    i_s_awlen   = len_t'(beats - 1);
    wait_handshake(CH_AW, "write address");
    for (int i = 0; i < beats; i++) begin
      baddr = addr + i * STRB_WIDTH;
      data  = DATA_WIDTH'($random(seed));
      strb  = partial ? STRB_WIDTH'($random(seed)) : '1;
      @(negedge clk);
      i_s_awvalid = 1'b0;
      i_s_wvalid  = 1'b0;
      // Idle gap between W beats
      if (stall_en) begin
        repeat ({$random(seed)} % 4) @(negedge clk);
      end
      i_s_wvalid = 1'b1;
      i_s_wdata  = data;
      i_s_wstrb  = strb;
      i_s_wlast  = (i == beats - 1);
      wait_handshake(CH_W, "write data");
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (strb[b] && baddr + b < MEM_BYTES) begin
          ref_mem[baddr + b] = data[b*8 +: 8];
        end
      end
    end
    @(negedge clk);
    i_s_wvalid = 1'b0;
    i_s_wlast  = 1'b0;
    wait_responses("write burst");
  endtask

  task automatic read_burst(input int addr, input int beats);
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH+1:0] ref_beat;
    rbeat_t                r_new;
    id = ID_WIDTH'($random(seed));
    for (int i = 0; i < beats; i++) begin
      ref_beat   = expected_read(addr + i * STRB_WIDTH);
      r_new.id   = id;
      r_new.resp = ref_beat[DATA_WIDTH +: 2];
      r_new.data = ref_beat[DATA_WIDTH-1:0];
      r_new.last = (i == beats - 1);
      exp_r.push_back(r_new);
    end
    @(negedge clk);
    i_s_arvalid = 1'b1;
    i_s_arid    = id;
    i_s_araddr  = ADDR_WIDTH'(addr);
    i_s_arlen   = len_t'(beats - 1);
    wait_handshake(CH_AR, "read address");
    @(negedge clk);
    i_s_arvalid = 1'b0;
    wait_responses("read burst");
  endtask

  task automatic random_bursts(input int count);
    int addr;
    int beats;
    bit partial;
    for (int n = 0; n < count; n++) begin
      beats   = 1 + {$random(seed)} % 16;
      addr    = ({$random(seed)} % MEM_DEPTH) * STRB_WIDTH;
      partial = 1'($random(seed));
      write_burst(addr, beats, partial);
      read_burst(addr, beats);
      read_burst(({$random(seed)} % MEM_DEPTH) * STRB_WIDTH, 1 + {$random(seed)} % 16);
    end
  endtask

  // Three beats below the end of the memory and three beyond it
  task automatic boundary_bursts();
    write_burst(MEM_BYTES - 3 * STRB_WIDTH, 6, 1'b0);
    read_burst(MEM_BYTES - 3 * STRB_WIDTH, 6);
    read_burst(MEM_BYTES, 2);
  endtask

  // Random back-pressure on the response channels
  always @(negedge clk) begin
    if (stall_en) begin
      i_s_bready = ({$random(seed)} % 3) != 0;
      i_s_rready = ({$random(seed)} % 3) != 0;
    end else begin
      i_s_bready = 1'b1;
      i_s_rready = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (i_arst_n && o_s_rvalid && i_s_rready) begin
      if (exp_r.size() == 0) begin
        report_failure("A read beat was delivered while no read beat was expected");
      end else begin
        r_exp = exp_r.pop_front();
        assert (o_s_rid === r_exp.id) else
          report_failure(value_error("o_s_rid", 32'(o_s_rid), 32'(r_exp.id)));
        assert (o_s_rresp === r_exp.resp) else
          report_failure(value_error("o_s_rresp", 32'(o_s_rresp), 32'(r_exp.resp)));
        assert (o_s_rdata === r_exp.data) else
          report_failure(value_error("o_s_rdata", 32'(o_s_rdata), 32'(r_exp.data)));
        assert (o_s_rlast === r_exp.last) else
          report_failure(value_error("o_s_rlast", 32'(o_s_rlast), 32'(r_exp.last)));
      end
    end
    if (i_arst_n && o_s_bvalid && i_s_bready) begin
      if (exp_b.size() == 0) begin
        report_failure("A write response was delivered while none was expected");
      end else begin
        b_exp = exp_b.pop_front();
        assert (o_s_bid === b_exp.id) else
          report_failure(value_error("o_s_bid", 32'(o_s_bid), 32'(b_exp.id)));
        assert (o_s_bresp === b_exp.resp) else
          report_failure(value_error("o_s_bresp", 32'(o_s_bresp), 32'(b_exp.resp)));
      end
    end
  end

  initial begin
    seed        = 82;
    clk         = 1'b0;
    i_arst_n    = 1'b0;
    stall_en    = 1'b0;
    i_s_awvalid = 1'b0;
    i_s_awid    = '0;
    i_s_awaddr  = '0;
    i_s_awlen   = '0;
    i_s_wvalid  = 1'b0;
    i_s_wdata   = '0;
    i_s_wstrb   = '0;
    i_s_wlast   = 1'b0;
    i_s_bready  = 1'b1;
    i_s_arvalid = 1'b0;
    i_s_arid    = '0;
    i_s_araddr  = '0;
    i_s_arlen   = '0;
    i_s_rready  = 1'b1;
    for (int a = 0; a < 2**ADDR_WIDTH; a++) begin
      ref_mem[a] = '0;
    end

    repeat (16) @(posedge clk);
    @(negedge clk);
    i_arst_n = 1'b1;

    // Fill the whole memory so every later read has known data
    for (int a = 0; a < MEM_BYTES; a += 16 * STRB_WIDTH) begin
      write_burst(a, 16, 1'b0);
    end

    random_bursts(12);
    boundary_bursts();

    stall_en = 1'b1;
    random_bursts(12);
    boundary_bursts();
    stall_en = 1'b0;

    // Quiet period to catch any late or duplicated response before the idle check
    repeat (20) @(negedge clk);
    if (o_s_awready && o_s_arready && !o_s_bvalid && !o_s_rvalid) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      report_failure("The DUT did not return to idle after the last burst");
    end
  end

endmodule

// ==== verilog.f ====
src/burst_pkg.sv
src/burst_split_wr.sv
src/burst_split_rd.sv
src/beat_mem.sv
src/burst_split_top.sv
verification/burst_split_tb.sv

// ==== Makefile ====
# Verilator flow for the burst splitter testbench

VERILATOR ?= verilator
TOP       ?= burst_split_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
